//--- rtl/isq_pkg.sv
package isq_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // queue geometry
   ////////////////////////////////////////////////////////////////////////////

   // number of queue lines
   localparam int ISQ_DEPTH = 8;
   // dispatch ports per cycle
   localparam int INST_PORT = 2;
   // physical register tag width
   localparam int TAG_W     = 5;
   // line index width, log2 of the depth
   localparam int ISQ_ADDR  = 3;

   ////////////////////////////////////////////////////////////////////////////
   // types
   ////////////////////////////////////////////////////////////////////////////

   // line index
   typedef logic [ISQ_ADDR-1:0] isq_idx_t;

   // physical register tag
   typedef logic [TAG_W-1:0] isq_tag_t;

   // renamed instruction word, 40 bits
   // an unused source never waits
   typedef struct packed {
      logic [6:0]  opcode;
      isq_tag_t    dst;
      isq_tag_t    src1;
      logic        src1_used;
      isq_tag_t    src2;
      logic        src2_used;
      logic [15:0] imm;
   } isq_inst_t;

endpackage

//--- rtl/isq_status_if.sv
`timescale 1ns/1ps

interface isq_status_if import isq_pkg::*; ();

   // per line ready, valid with no pending source
   logic [ISQ_DEPTH-1:0] rdy;
   // contents of every line
   isq_inst_t            lin_inst [ISQ_DEPTH];
   // grant from the selector
   logic                 gnt_valid;
   // granted line, freed at the next edge
   isq_idx_t             gnt_idx;

   // queue array side
   modport queue_mp (
      output rdy,
      output lin_inst,
      input  gnt_valid,
      input  gnt_idx
   );

   // selector side
   modport select_mp (
      input  rdy,
      input  lin_inst,
      output gnt_valid,
      output gnt_idx
   );

endinterface

//--- rtl/isq_line.sv
`timescale 1ns/1ps

module isq_line import isq_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   // dispatch write into this line
   input  logic      wr_en_i,
   input  isq_inst_t wr_inst_i,
   // release by grant or by flush
   input  logic      free_i,
   input  logic      flush_i,
   // writeback broadcast
   input  logic      wb_valid_i,
   input  isq_tag_t  wb_tag_i,
   output logic      valid_o,
   output logic      ready_o,
   output isq_inst_t inst_o
);

   logic      valid_q;
   logic      wait1_q;
   logic      wait2_q;
   isq_inst_t inst_q;
   logic      wb_hit1;
   logic      wb_hit2;
   logic      wr_wait1;
   logic      wr_wait2;

   // wakeup compare against the stored sources
   assign wb_hit1 = wb_valid_i && (wb_tag_i == inst_q.src1);
   assign wb_hit2 = wb_valid_i && (wb_tag_i == inst_q.src2);

   // incoming sources, a same-cycle writeback counts as ready
   assign wr_wait1 = wr_inst_i.src1_used && !(wb_valid_i && (wb_tag_i == wr_inst_i.src1));
   assign wr_wait2 = wr_inst_i.src2_used && !(wb_valid_i && (wb_tag_i == wr_inst_i.src2));

   ////////////////////////////////////////////////////////////////////////////
   // valid and wait bits
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         valid_q <= 1'b0;
         wait1_q <= 1'b0;
         wait2_q <= 1'b0;
      end
      else if (flush_i)
         valid_q <= 1'b0;
      else if (wr_en_i)
      begin
         // write wins over a release in the same cycle
         valid_q <= 1'b1;
         wait1_q <= wr_wait1;
         wait2_q <= wr_wait2;
      end
      else
      begin
         if (free_i)
            valid_q <= 1'b0;
         if (wb_hit1)
            wait1_q <= 1'b0;
         if (wb_hit2)
            wait2_q <= 1'b0;
      end
   end

   // instruction word
   always_ff @(posedge clk)
   begin
      if (wr_en_i)
         inst_q <= wr_inst_i;
   end

   assign valid_o = valid_q;
   assign ready_o = valid_q && !wait1_q && !wait2_q;
   assign inst_o  = inst_q;

   // an occupied line is only rewritten in the cycle it is released
   a_no_overwrite : assert property (@(posedge clk) disable iff (!rst_n)
      wr_en_i |-> (!valid_q || free_i));

endmodule

//--- rtl/isq.sv
`timescale 1ns/1ps

module isq import isq_pkg::*;
(
   input  logic               clk,
   input  logic               rst_n,
   // dispatch, one strobe per port
   input  logic [INST_PORT-1:0] disp_valid_i,
   input  isq_inst_t          disp_inst_i [INST_PORT],
   input  logic               flush_i,
   // writeback broadcast
   input  logic               wb_valid_i,
   input  isq_tag_t           wb_tag_i,
   output logic               isq_full_o,
   isq_status_if.queue_mp     st
);

   logic [ISQ_DEPTH-1:0] line_valid;
   logic [ISQ_DEPTH-1:0] line_ready;
   logic [ISQ_DEPTH-1:0] line_rel;
   logic [ISQ_DEPTH-1:0] line_free;
   logic [ISQ_DEPTH-1:0] line_wr;
   isq_inst_t            line_wr_inst [ISQ_DEPTH];
   isq_inst_t            line_inst [ISQ_DEPTH];
   logic                 disp_ok;
   logic [ISQ_ADDR:0]    free_cnt;
   logic                 full_q;

   // strobes while full or flushing are dropped
   assign disp_ok = !full_q && !flush_i;

   // granted line counts as free this cycle
   always_comb
   begin
      for (int l = 0; l < ISQ_DEPTH; l++)
      begin
         line_rel[l] = st.gnt_valid && (st.gnt_idx == isq_idx_t'(l));
      end
   end

   assign line_free = ~line_valid | line_rel;

   ////////////////////////////////////////////////////////////////////////////
   // dispatch steering
   ////////////////////////////////////////////////////////////////////////////
   // each strobed port takes the next lowest free line, port 0 first
   always_comb
   begin
      logic placed;
      line_wr = '0;
      for (int l = 0; l < ISQ_DEPTH; l++)
      begin
         line_wr_inst[l] = disp_inst_i[0];
      end
      for (int p = 0; p < INST_PORT; p++)
      begin
         placed = 1'b0;
         for (int l = 0; l < ISQ_DEPTH; l++)
         begin
            if (disp_ok && disp_valid_i[p] && !placed && line_free[l] && !line_wr[l])
            begin
               line_wr[l]      = 1'b1;
               line_wr_inst[l] = disp_inst_i[p];
               placed          = 1'b1;
            end
         end
      end
   end

   // line array
   for (genvar l = 0; l < ISQ_DEPTH; l++)
   begin : g_line
      isq_line i_line (
         .clk        (clk),
         .rst_n      (rst_n),
         .wr_en_i    (line_wr[l]),
         .wr_inst_i  (line_wr_inst[l]),
         .free_i     (line_rel[l]),
         .flush_i    (flush_i),
         .wb_valid_i (wb_valid_i),
         .wb_tag_i   (wb_tag_i),
         .valid_o    (line_valid[l]),
         .ready_o    (line_ready[l]),
         .inst_o     (line_inst[l])
      );
   end

   assign st.rdy      = line_ready;
   assign st.lin_inst = line_inst;

   ////////////////////////////////////////////////////////////////////////////
   // full flag
   ////////////////////////////////////////////////////////////////////////////
   // lines left free after this edge
   always_comb
   begin
      free_cnt = '0;
      for (int l = 0; l < ISQ_DEPTH; l++)
      begin
         free_cnt = free_cnt + {{ISQ_ADDR{1'b0}}, line_free[l] & ~line_wr[l]};
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         full_q <= 1'b0;
      else if (flush_i)
         full_q <= 1'b0;
      else
         full_q <= (free_cnt < INST_PORT);
   end

   assign isq_full_o = full_q;

   // selector only grants occupied ready lines
   a_gnt_ready : assert property (@(posedge clk) disable iff (!rst_n)
      st.gnt_valid |-> (line_valid[st.gnt_idx] && line_ready[st.gnt_idx]));

endmodule

//--- rtl/isq_select.sv
`timescale 1ns/1ps

module isq_select import isq_pkg::*;
(
   input  logic           clk,
   input  logic           rst_n,
   input  logic           flush_i,
   // issue pulse
   output logic           iss_valid_o,
   output isq_idx_t       iss_idx_o,
   output isq_inst_t      iss_inst_o,
   isq_status_if.select_mp st
);

   logic      gnt_valid;
   isq_idx_t  gnt_idx;
   logic      iss_valid_q;
   isq_idx_t  iss_idx_q;
   isq_inst_t iss_inst_q;

   ////////////////////////////////////////////////////////////////////////////
   // priority pick
   ////////////////////////////////////////////////////////////////////////////
   // scan from the top so the lowest ready index is left
   always_comb
   begin
      gnt_idx = '0;
      for (int i = ISQ_DEPTH - 1; i >= 0; i--)
      begin
         if (st.rdy[i])
            gnt_idx = isq_idx_t'(i);
      end
   end

   // no grant while flushing
   assign gnt_valid    = (|st.rdy) && !flush_i;
   assign st.gnt_valid = gnt_valid;
   assign st.gnt_idx   = gnt_idx;

   // issue register, one cycle pulse
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         iss_valid_q <= 1'b0;
      else
         iss_valid_q <= gnt_valid;
   end

   // payload follows the grant
   always_ff @(posedge clk)
   begin
      iss_idx_q  <= gnt_idx;
      iss_inst_q <= st.lin_inst[gnt_idx];
   end

   assign iss_valid_o = iss_valid_q;
   assign iss_idx_o   = iss_idx_q;
   assign iss_inst_o  = iss_inst_q;

   // freed line issues again next cycle only after a refill with a new word
   a_no_repeat : assert property (@(posedge clk) disable iff (!rst_n)
      iss_valid_q |=> !(iss_valid_q && (iss_idx_q == $past(iss_idx_q)) &&
                        (iss_inst_q == $past(iss_inst_q))));

endmodule

//--- rtl/isq_top.sv
`timescale 1ns/1ps

module isq_top import isq_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   // dispatch
   input  logic [INST_PORT-1:0] disp_valid_i,
   input  isq_inst_t            disp_inst_i [INST_PORT],
   output logic                 isq_full_o,
   // writeback broadcast
   input  logic                 wb_valid_i,
   input  isq_tag_t             wb_tag_i,
   // flush of the whole queue
   input  logic                 flush_i,
   // issue
   output logic                 iss_valid_o,
   output isq_idx_t             iss_idx_o,
   output isq_inst_t            iss_inst_o
);

   // line status and grant between queue and selector
   isq_status_if st ();

   ////////////////////////////////////////////////////////////////////////////
   // queue array
   ////////////////////////////////////////////////////////////////////////////
   isq i_isq (
      .clk          (clk),
      .rst_n        (rst_n),
      .disp_valid_i (disp_valid_i),
      .disp_inst_i  (disp_inst_i),
      .flush_i      (flush_i),
      .wb_valid_i   (wb_valid_i),
      .wb_tag_i     (wb_tag_i),
      .isq_full_o   (isq_full_o),
      .st           (st.queue_mp)
   );

   // selector and issue register
   isq_select i_select (
      .clk         (clk),
      .rst_n       (rst_n),
      .flush_i     (flush_i),
      .iss_valid_o (iss_valid_o),
      .iss_idx_o   (iss_idx_o),
      .iss_inst_o  (iss_inst_o),
      .st          (st.select_mp)
   );

endmodule

//--- tests/isq_checker.sv
`timescale 1ns/1ps

module isq_checker import isq_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   // DUT inputs
   input  logic [INST_PORT-1:0] disp_valid_i,
   input  isq_inst_t            disp_inst_i [INST_PORT],
   input  logic                 wb_valid_i,
   input  isq_tag_t             wb_tag_i,
   input  logic                 flush_i,
   // DUT outputs
   input  logic                 isq_full_i,
   input  logic                 iss_valid_i,
   input  isq_idx_t             iss_idx_i,
   input  isq_inst_t            iss_inst_i,
   output int                   err_cnt_o,
   output int                   chk_cnt_o
);

   // reference copy of every queue line
   logic      m_valid [ISQ_DEPTH];
   logic      m_wait1 [ISQ_DEPTH];
   logic      m_wait2 [ISQ_DEPTH];
   isq_inst_t m_inst  [ISQ_DEPTH];
   logic      exp_full;
   logic      exp_valid;
   isq_idx_t  exp_idx;
   isq_inst_t exp_inst;
   int        n_err = 0;
   int        n_chk = 0;

   assign err_cnt_o = n_err;
   assign chk_cnt_o = n_chk;

   ////////////////////////////////////////////////////////////////////////////
   // model step on every rising edge
   ////////////////////////////////////////////////////////////////////////////
   always @(posedge clk or negedge rst_n)
   begin : model_step
      int   pick;
      int   cnt;
      logic gnt;
      logic placed;
      logic avail [ISQ_DEPTH];
      if (!rst_n)
      begin
         for (int l = 0; l < ISQ_DEPTH; l++)
         begin
            m_valid[l] = 1'b0;
            m_wait1[l] = 1'b0;
            m_wait2[l] = 1'b0;
            m_inst[l]  = '0;
         end
         exp_full  = 1'b0;
         exp_valid = 1'b0;
         exp_idx   = '0;
         exp_inst  = '0;
      end
      else
      begin
         // lowest ready line wins
         pick = -1;
         for (int l = ISQ_DEPTH - 1; l >= 0; l--)
         begin
            if (m_valid[l] && !m_wait1[l] && !m_wait2[l])
               pick = l;
         end
         gnt       = (pick >= 0) && !flush_i;
         exp_valid = gnt;
         if (gnt)
         begin
            exp_idx  = isq_idx_t'(pick);
            exp_inst = m_inst[pick];
         end
         // wakeup on held lines, release of the granted one
         for (int l = 0; l < ISQ_DEPTH; l++)
         begin
            if (wb_valid_i && (wb_tag_i == m_inst[l].src1))
               m_wait1[l] = 1'b0;
            if (wb_valid_i && (wb_tag_i == m_inst[l].src2))
               m_wait2[l] = 1'b0;
            if (gnt && (l == pick))
               m_valid[l] = 1'b0;
            avail[l] = !m_valid[l];
         end
         // port 0 to the lowest free line, port 1 to the next
         if (!exp_full && !flush_i)
         begin
            for (int p = 0; p < INST_PORT; p++)
            begin
               placed = 1'b0;
               for (int l = 0; l < ISQ_DEPTH; l++)
               begin
                  if (disp_valid_i[p] && !placed && avail[l])
                  begin
                     m_valid[l] = 1'b1;
                     m_inst[l]  = disp_inst_i[p];
                     m_wait1[l] = disp_inst_i[p].src1_used &&
                        !(wb_valid_i && (wb_tag_i == disp_inst_i[p].src1));
                     m_wait2[l] = disp_inst_i[p].src2_used &&
                        !(wb_valid_i && (wb_tag_i == disp_inst_i[p].src2));
                     avail[l]   = 1'b0;
                     placed     = 1'b1;
                  end
               end
            end
         end
         // flush empties everything
         cnt = 0;
         for (int l = 0; l < ISQ_DEPTH; l++)
         begin
            if (flush_i)
               m_valid[l] = 1'b0;
            if (avail[l])
               cnt++;
         end
         exp_full = !flush_i && (cnt < INST_PORT);
      end
   end

   // outputs settled half a cycle after the edge
   always @(negedge clk)
   begin
      if (rst_n)
      begin
         n_chk++;
         if (iss_valid_i !== exp_valid)
         begin
            n_err++;
            $display("error %0t: iss_valid_o is %b, expected %b",
               $time, iss_valid_i, exp_valid);
         end
         else if (exp_valid && ((iss_idx_i !== exp_idx) || (iss_inst_i !== exp_inst)))
         begin
            n_err++;
            $display("error %0t: issue line %0d inst %h, expected line %0d inst %h",
               $time, iss_idx_i, iss_inst_i, exp_idx, exp_inst);
         end
         if (isq_full_i !== exp_full)
         begin
            n_err++;
            $display("error %0t: isq_full_o is %b, expected %b",
               $time, isq_full_i, exp_full);
         end
      end
   end

endmodule

//--- tests/isq_tb.sv
`timescale 1ns/1ps

module isq_tb import isq_pkg::*; ();

   // random cycles after the directed part
   localparam int N_CYC = 3000;

   logic                 clk;
   logic                 rst_n;
   logic [INST_PORT-1:0] disp_valid;
   isq_inst_t            disp_inst [INST_PORT];
   logic                 isq_full;
   logic                 wb_valid;
   isq_tag_t             wb_tag;
   logic                 flush;
   logic                 iss_valid;
   isq_idx_t             iss_idx;
   isq_inst_t            iss_inst;
   int                   err_cnt;
   int                   chk_cnt;
   logic [31:0]          lfsr;

   isq_top i_dut (
      .clk          (clk),
      .rst_n        (rst_n),
      .disp_valid_i (disp_valid),
      .disp_inst_i  (disp_inst),
      .isq_full_o   (isq_full),
      .wb_valid_i   (wb_valid),
      .wb_tag_i     (wb_tag),
      .flush_i      (flush),
      .iss_valid_o  (iss_valid),
      .iss_idx_o    (iss_idx),
      .iss_inst_o   (iss_inst)
   );

   isq_checker i_checker (
      .clk          (clk),
      .rst_n        (rst_n),
      .disp_valid_i (disp_valid),
      .disp_inst_i  (disp_inst),
      .wb_valid_i   (wb_valid),
      .wb_tag_i     (wb_tag),
      .flush_i      (flush),
      .isq_full_i   (isq_full),
      .iss_valid_i  (iss_valid),
      .iss_idx_i    (iss_idx),
      .iss_inst_i   (iss_inst),
      .err_cnt_o    (err_cnt),
      .chk_cnt_o    (chk_cnt)
   );

   // 8 ns clock
   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // random source
   ////////////////////////////////////////////////////////////////////////////
   // galois lfsr, one step per bit
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int b = 0; b < n; b++)
      begin
         r    = {r[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      end
      return r;
   endfunction

   // tags drawn from a pool of 8
   function automatic isq_inst_t rand_inst();
      isq_inst_t i;
      i.opcode    = 7'(take_bits(7));
      i.dst       = isq_tag_t'(take_bits(3));
      i.src1      = isq_tag_t'(take_bits(3));
      i.src1_used = 1'(take_bits(1));
      i.src2      = isq_tag_t'(take_bits(3));
      i.src2_used = 1'(take_bits(1));
      i.imm       = 16'(take_bits(16));
      return i;
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   initial
   begin
      isq_inst_t d;
      lfsr         = 32'h2241;
      rst_n        = 1'b0;
      disp_valid   = '0;
      disp_inst[0] = '0;
      disp_inst[1] = '0;
      wb_valid     = 1'b0;
      wb_tag       = '0;
      flush        = 1'b0;
      repeat (4) @(posedge clk);
      #1 rst_n = 1'b1;
      // no sources, then one source waiting on tag 5
      next_cycle();
      d            = '0;
      d.opcode     = 7'h13;
      d.imm        = 16'h00a5;
      disp_valid   = 2'b01;
      disp_inst[0] = d;
      next_cycle();
      d.opcode     = 7'h33;
      d.src1       = 5'd5;
      d.src1_used  = 1'b1;
      disp_inst[0] = d;
      next_cycle();
      disp_valid   = '0;
      repeat (3) next_cycle();
      wb_valid     = 1'b1;
      wb_tag       = 5'd5;
      // same-edge wakeup on both ports
      next_cycle();
      d.src1       = 5'd6;
      d.src2       = 5'd6;
      d.src2_used  = 1'b1;
      disp_inst[0] = d;
      disp_inst[1] = d;
      disp_valid   = 2'b11;
      wb_tag       = 5'd6;
      next_cycle();
      disp_valid   = '0;
      wb_valid     = 1'b0;
      repeat (4) next_cycle();
      // random traffic
      for (int c = 0; c < N_CYC; c++)
      begin
         for (int p = 0; p < INST_PORT; p++)
         begin
            disp_valid[p] = !isq_full && (take_bits(3) < 3);
            disp_inst[p]  = rand_inst();
         end
         wb_valid = 1'(take_bits(1));
         wb_tag   = isq_tag_t'(take_bits(3));
         flush    = (take_bits(6) == 0);
         next_cycle();
      end
      disp_valid = '0;
      wb_valid   = 1'b0;
      flush      = 1'b0;
      repeat (10) next_cycle();
      $display("isq_tb: %0d checks, %0d errors", chk_cnt, err_cnt);
      if ((err_cnt == 0) && (chk_cnt > 0))
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

   // watchdog
   initial
   begin
      #((N_CYC + 100) * 8);
      $display("timeout: the run did not reach its end in time");
      $display("Checks failed");
      $finish;
   end

endmodule

//--- vlog.f
rtl/isq_pkg.sv
rtl/isq_status_if.sv
rtl/isq_line.sv
rtl/isq.sv
rtl/isq_select.sv
rtl/isq_top.sv
tests/isq_checker.sv
tests/isq_tb.sv

//--- Bender.yml
package:
  name: isq

sources:
  - rtl/isq_pkg.sv
  - rtl/isq_status_if.sv
  - rtl/isq_line.sv
  - rtl/isq.sv
  - rtl/isq_select.sv
  - rtl/isq_top.sv
  - target: test
    files:
      - tests/isq_checker.sv
      - tests/isq_tb.sv
